// File: common/rv_exec_pkg.sv
package rv_exec_pkg;

    // ------------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------------

    localparam int XLEN   = 32;             // Integer register width
    localparam int REG_AW = 5;              // x0..x31

    // ------------------------------------------------------------------------
    // Major opcodes, instr[6:0]
    // ------------------------------------------------------------------------

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ------------------------------------------------------------------------
    // ALU operation codes
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_MOV  = 4'd10                    // Passes the right operand
    } alu_op_t;

    // ------------------------------------------------------------------------
    // Compare operation codes
    // ------------------------------------------------------------------------

    // Encoded as the branch funct3 field, so the decoder can cast directly
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_t;

endpackage

// File: design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             instr_valid_i,
    input  logic [31:0]                      instr_i,
    output logic [rv_exec_pkg::REG_AW-1:0]   rs1_addr_o,
    output logic [rv_exec_pkg::REG_AW-1:0]   rs2_addr_o,
    output rv_exec_pkg::alu_op_t             alu_op_o,
    output rv_exec_pkg::cmp_op_t             cmp_op_o,
    output logic [rv_exec_pkg::XLEN-1:0]     imm_o,
    output logic                             use_imm_o,
    output logic                             wb_valid_o,
    output logic [rv_exec_pkg::REG_AW-1:0]   wb_addr_o,
    output logic                             br_valid_o,
    output logic                             illegal_o
);

    // Instruction fields
    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [rv_exec_pkg::REG_AW-1:0] rd;

    // Kind of the current instruction
    logic is_wb;
    logic is_br;
    logic bad;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rs2_addr_o = instr_i[24:20];
    assign cmp_op_o   = rv_exec_pkg::cmp_op_t'(funct3);

    // funct3 to ALU operation, alt selects SUB and SRA
    function automatic rv_exec_pkg::alu_op_t funct3_to_alu(input logic [2:0] f3,
                                                           input logic       alt);
        rv_exec_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
            3'b001:  op = rv_exec_pkg::ALU_SLL;
            3'b010:  op = rv_exec_pkg::ALU_SLT;
            3'b011:  op = rv_exec_pkg::ALU_SLTU;
            3'b100:  op = rv_exec_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
            3'b110:  op = rv_exec_pkg::ALU_OR;
            default: op = rv_exec_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // ------------------------------------------------------------------------
    // Combinational decode
    // ------------------------------------------------------------------------

    always_comb begin
        alu_op_o   = rv_exec_pkg::ALU_ADD;
        imm_o      = {{(rv_exec_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]}; // I-type
        use_imm_o  = 1'b0;
        rs1_addr_o = instr_i[19:15];
        is_wb      = 1'b0;
        is_br      = 1'b0;
        bad        = 1'b0;

        case (opcode)
            rv_exec_pkg::OPC_OP: begin
                is_wb    = 1'b1;
                alu_op_o = funct3_to_alu(funct3, funct7[5]);
                // Only SUB and SRA accept the alternate funct7
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    bad = 1'b1;
                end
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                is_wb     = 1'b1;
                use_imm_o = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_o    = {{(rv_exec_pkg::XLEN-5){1'b0}}, instr_i[24:20]}; // Shamt
                    alu_op_o = funct3_to_alu(funct3, funct7[5]);
                    if (funct7 != 7'b0000000 &&
                        !(funct7 == 7'b0100000 && funct3 == 3'b101)) begin
                        bad = 1'b1;
                    end
                end else begin
                    alu_op_o = funct3_to_alu(funct3, 1'b0); // No SUBI
                end
            end
            rv_exec_pkg::OPC_LUI: begin
                is_wb      = 1'b1;
                use_imm_o  = 1'b1;
                alu_op_o   = rv_exec_pkg::ALU_MOV;
                rs1_addr_o = '0;
                imm_o      = {instr_i[31:12], 12'b0};
            end
            rv_exec_pkg::OPC_BRANCH: begin
                is_br = 1'b1;
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    bad = 1'b1;                  // No such condition
                end
            end
            default: begin
                bad = 1'b1;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Writeback tag and kind flags
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            br_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= instr_valid_i & is_wb & ~bad & (rd != '0);
            br_valid_o <= instr_valid_i & is_br & ~bad;
            illegal_o  <= instr_valid_i & bad;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            wb_addr_o <= rd;
        end
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic [rv_exec_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [rv_exec_pkg::REG_AW-1:0] rs2_addr_i,
    input  logic                           wr_en_i,
    input  logic [rv_exec_pkg::REG_AW-1:0] wr_addr_i,
    input  logic [rv_exec_pkg::XLEN-1:0]   wr_data_i,
    output logic [rv_exec_pkg::XLEN-1:0]   rs1_data_o,
    output logic [rv_exec_pkg::XLEN-1:0]   rs2_data_o
);

    // x0 has no storage
    logic [rv_exec_pkg::XLEN-1:0] regs [1:2**rv_exec_pkg::REG_AW-1];

    // Read with write-through of the pending writeback
    function automatic logic [rv_exec_pkg::XLEN-1:0] read_reg(
        input logic [rv_exec_pkg::REG_AW-1:0] addr);
        logic [rv_exec_pkg::XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            data = wr_data_i;                   // Bypass
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_reg(rs1_addr_i);
    end

    always_comb begin
        rs2_data_o = read_reg(rs2_addr_i);
    end

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 2**rv_exec_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: alu/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,

    input  logic [rv_exec_pkg::XLEN-1:0] op_left_i,
    input  logic [rv_exec_pkg::XLEN-1:0] op_right_i,
    input  rv_exec_pkg::alu_op_t         op_opcode_i,
    output logic [rv_exec_pkg::XLEN-1:0] op_result_o,

    input  logic [rv_exec_pkg::XLEN-1:0] cmp_left_i,
    input  logic [rv_exec_pkg::XLEN-1:0] cmp_right_i,
    input  rv_exec_pkg::cmp_op_t         cmp_opcode_i,
    output logic                         cmp_result_o
);

    // ------------------------------------------------------------------------
    // Operation result mux
    // ------------------------------------------------------------------------

    logic [rv_exec_pkg::XLEN-1:0] result_mux;
    logic [4:0]                   shamt;        // log2(XLEN) bits
    logic                         op_lt_s;
    logic                         op_lt_u;

    assign shamt   = op_right_i[4:0];
    assign op_lt_s = $signed(op_left_i) < $signed(op_right_i);
    assign op_lt_u = op_left_i < op_right_i;

    always_comb begin
        result_mux = '0;
        case (op_opcode_i)
            rv_exec_pkg::ALU_ADD:  result_mux = op_left_i + op_right_i;
            rv_exec_pkg::ALU_SUB:  result_mux = op_left_i - op_right_i;
            rv_exec_pkg::ALU_SLL:  result_mux = op_left_i << shamt;
            rv_exec_pkg::ALU_SLT:  result_mux = {{(rv_exec_pkg::XLEN-1){1'b0}}, op_lt_s};
            rv_exec_pkg::ALU_SLTU: result_mux = {{(rv_exec_pkg::XLEN-1){1'b0}}, op_lt_u};
            rv_exec_pkg::ALU_XOR:  result_mux = op_left_i ^ op_right_i;
            rv_exec_pkg::ALU_SRL:  result_mux = op_left_i >> shamt;
            rv_exec_pkg::ALU_SRA:  result_mux = $signed(op_left_i) >>> shamt; // Keeps sign
            rv_exec_pkg::ALU_OR:   result_mux = op_left_i | op_right_i;
            rv_exec_pkg::ALU_AND:  result_mux = op_left_i & op_right_i;
            rv_exec_pkg::ALU_MOV:  result_mux = op_right_i;
            default:               result_mux = '0;
        endcase
    end

    // Result register, holds between strobes
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            op_result_o <= result_mux;
        end
    end

    // ------------------------------------------------------------------------
    // Branch comparator
    // ------------------------------------------------------------------------

    logic cmp_eq;
    logic cmp_lt_s;
    logic cmp_lt_u;

    assign cmp_eq   = cmp_left_i == cmp_right_i;
    assign cmp_lt_s = $signed(cmp_left_i) < $signed(cmp_right_i);
    assign cmp_lt_u = cmp_left_i < cmp_right_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmp_result_o <= 1'b0;
        end else if (clk_en_i) begin
            case (cmp_opcode_i)
                rv_exec_pkg::CMP_EQ:  cmp_result_o <= cmp_eq;
                rv_exec_pkg::CMP_NE:  cmp_result_o <= ~cmp_eq;
                rv_exec_pkg::CMP_LT:  cmp_result_o <= cmp_lt_s;
                rv_exec_pkg::CMP_GE:  cmp_result_o <= ~cmp_lt_s;
                rv_exec_pkg::CMP_LTU: cmp_result_o <= cmp_lt_u;
                rv_exec_pkg::CMP_GEU: cmp_result_o <= ~cmp_lt_u;
                default:              cmp_result_o <= 1'b0; // funct3 010/011
            endcase
        end
    end

endmodule

// File: design/rv_exec_top.sv
`timescale 1ns/10ps

module rv_exec_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           instr_valid_i,
    input  logic [31:0]                    instr_i,
    output logic                           wb_valid_o,
    output logic [rv_exec_pkg::REG_AW-1:0] wb_addr_o,
    output logic [rv_exec_pkg::XLEN-1:0]   wb_data_o,
    output logic                           br_valid_o,
    output logic                           br_taken_o,
    output logic                           illegal_o
);

    // Decode outputs
    logic [rv_exec_pkg::REG_AW-1:0] rs1_addr;
    logic [rv_exec_pkg::REG_AW-1:0] rs2_addr;
    rv_exec_pkg::alu_op_t           alu_op;
    rv_exec_pkg::cmp_op_t           cmp_op;
    logic [rv_exec_pkg::XLEN-1:0]   imm;
    logic                           use_imm;

    // Operands
    logic [rv_exec_pkg::XLEN-1:0]   rs1_data;
    logic [rv_exec_pkg::XLEN-1:0]   rs2_data;
    logic [rv_exec_pkg::XLEN-1:0]   op_right;

    assign op_right = use_imm ? imm : rs2_data;

    rv_decode u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .alu_op_o      (alu_op),
        .cmp_op_o      (cmp_op),
        .imm_o         (imm),
        .use_imm_o     (use_imm),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .br_valid_o    (br_valid_o),
        .illegal_o     (illegal_o)
    );

    // Written back from the registered ALU result
    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_en_i    (wb_valid_o),
        .wr_addr_i  (wb_addr_o),
        .wr_data_i  (wb_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (instr_valid_i),      // Strobe acts as the enable
        .op_left_i    (rs1_data),
        .op_right_i   (op_right),
        .op_opcode_i  (alu_op),
        .op_result_o  (wb_data_o),
        .cmp_left_i   (rs1_data),
        .cmp_right_i  (rs2_data),
        .cmp_opcode_i (cmp_op),
        .cmp_result_o (br_taken_o)
    );

endmodule

// File: verif/rv_exec_props.sv
`timescale 1ns/10ps

module rv_exec_props (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           instr_valid_i,
    input logic                           wb_valid_i,
    input logic [rv_exec_pkg::REG_AW-1:0] wb_addr_i,
    input logic                           br_valid_i,
    input logic                           illegal_i
);

    logic [2:0] flags;

    assign flags = {wb_valid_i, br_valid_i, illegal_i};

    reset_clears_flags: assert property (@(posedge clk_i) !rst_n_i |=> flags == 3'b000)
        else $error("Flag high in the cycle after reset");

    // Every flag traces back to a strobe one cycle earlier
    flag_needs_strobe: assert property (@(posedge clk_i) !instr_valid_i |=> flags == 3'b000)
        else $error("Flag high without a strobe in the previous cycle");

    no_x0_writeback: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                      wb_valid_i |-> wb_addr_i != '0)
        else $error("Writeback to x0 reported");

    single_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(flags))
        else $error("More than one flag high");

endmodule

bind rv_exec_top rv_exec_props u_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .wb_addr_i     (wb_addr_o),
    .br_valid_i    (br_valid_o),
    .illegal_i     (illegal_o)
);

// File: verif/rv_exec_tb.sv
`timescale 1ns/10ps

module rv_exec_tb;

    localparam int N_RR    = 160;
    localparam int N_RI    = 160;
    localparam int N_BR    = 120;
    localparam int N_CHAIN = 64;
    localparam int N_IDLE  = 60;
    localparam int N_ILL   = 40;
    // Reset, preload, sign-pair reloads, gaps of up to 3, reads and drains
    localparam int MAX_CYCLES = 4 + 62 + N_RR + N_RI + 3 * N_BR + N_CHAIN + 2
                              + 4 * N_IDLE + 35 + 24 + N_ILL + 6 * 3;

    localparam logic [1:0] K_WB   = 2'd0;
    localparam logic [1:0] K_BR   = 2'd1;
    localparam logic [1:0] K_ILL  = 2'd2;
    localparam logic [1:0] K_NONE = 2'd3;   // Legal, but no flag (rd = x0)

    typedef struct packed {
        logic [1:0]                     kind;
        logic [rv_exec_pkg::REG_AW-1:0] rd;
        logic [rv_exec_pkg::XLEN-1:0]   data;
        logic                           taken;
    } exp_t;

    logic                           clk_i;
    logic                           rst_n_i;
    logic                           instr_valid_i;
    logic [31:0]                    instr_i;
    logic                           wb_valid_o;
    logic [rv_exec_pkg::REG_AW-1:0] wb_addr_o;
    logic [rv_exec_pkg::XLEN-1:0]   wb_data_o;
    logic                           br_valid_o;
    logic                           br_taken_o;
    logic                           illegal_o;

    logic [31:0]                  lfsr = 32'hce5bc757;
    logic [rv_exec_pkg::XLEN-1:0] ref_regs [0:31];
    exp_t                         exp_q [$];
    int                           checks = 0;
    int                           errors = 0;
    int                           checks_mark = 0;
    int                           errors_mark = 0;

    rv_exec_top dut0 (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .br_valid_o    (br_valid_o),
        .br_taken_o    (br_taken_o),
        .illegal_o     (illegal_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_exec_pkg::OPC_OP_IMM};
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << sh;
            3'b010:  r = {31'b0, (a[31] != b[31]) ? a[31] : a < b};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101:  r = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic ref_cmp(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
        logic lt;
        logic r;
        lt = (a[31] != b[31]) ? a[31] : a < b;
        case (f3[2:1])
            2'b00:   r = (a == b) ^ f3[0];
            2'b10:   r = lt ^ f3[0];
            default: r = (a < b) ^ f3[0];
        endcase
        return r;
    endfunction

    function automatic exp_t ref_exec(input logic [31:0] ins);
        exp_t       e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       legal;
        f3     = ins[14:12];
        f7     = ins[31:25];
        e      = '0;
        e.rd   = ins[11:7];
        e.kind = K_WB;
        legal  = 1'b1;
        case (ins[6:0])
            rv_exec_pkg::OPC_OP: begin
                legal  = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                e.data = ref_alu(f3, f7[5], ref_regs[ins[19:15]], ref_regs[ins[24:20]]);
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    legal  = f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b101);
                    e.data = ref_alu(f3, f7[5], ref_regs[ins[19:15]], {27'b0, ins[24:20]});
                end else begin
                    e.data = ref_alu(f3, 1'b0, ref_regs[ins[19:15]],
                                     {{20{ins[31]}}, ins[31:20]});
                end
            end
            rv_exec_pkg::OPC_LUI: e.data = {ins[31:12], 12'b0};
            rv_exec_pkg::OPC_BRANCH: begin
                legal   = f3 != 3'b010 && f3 != 3'b011;
                e.kind  = K_BR;
                e.taken = ref_cmp(f3, ref_regs[ins[19:15]], ref_regs[ins[24:20]]);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e.kind = K_ILL;
        end else if (e.kind == K_WB && e.rd == '0) begin
            e.kind = K_NONE;
        end
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------

    task automatic issue(input logic [31:0] ins);
        exp_t e;
        @(posedge clk_i);
        #10;
        e             = ref_exec(ins);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        if (e.kind == K_WB) begin
            ref_regs[e.rd] = e.data;
        end
        exp_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #10;
            instr_valid_i = 1'b0;
            instr_i       = rand_bits(32);  // Must be ignored
        end
    endtask

    // LUI plus ADDI, upper part corrected for the sign of the low part
    task automatic load_value(input logic [4:0] rd, input logic [31:0] v);
        issue({v[31:12] + {19'b0, v[11]}, rd, rv_exec_pkg::OPC_LUI});
        issue(i_type(v[11:0], rd, 3'b000, rd));
    endtask

    task automatic apply_reset(input int n);
        @(posedge clk_i);
        #10;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        repeat (n) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
    endtask

    task automatic finish_test(input string name);
        idle(1);
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        $display("%s: %0d checks, %0d failed", name, checks - checks_mark, errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic flag_fail(input string what, input logic [2:0] exp_flags);
        errors++;
        $display("[FAIL] %0t ns: %s, flags wb/br/ill = %b, expected %b", $time, what,
                 {wb_valid_o, br_valid_o, illegal_o}, exp_flags);
    endtask

    task automatic check_wb(input logic [rv_exec_pkg::REG_AW-1:0] exp_addr,
                            input logic [rv_exec_pkg::XLEN-1:0]   exp_data);
        checks++;
        if ({wb_valid_o, br_valid_o, illegal_o} !== 3'b100) begin
            flag_fail("writeback", 3'b100);
        end else if (wb_addr_o !== exp_addr || wb_data_o !== exp_data) begin
            errors++;
            $display("[FAIL] %0t ns: wrote x%0d = %h, expected x%0d = %h", $time,
                     wb_addr_o, wb_data_o, exp_addr, exp_data);
        end
    endtask

    task automatic check_branch(input logic exp_taken);
        checks++;
        if ({wb_valid_o, br_valid_o, illegal_o} !== 3'b010) begin
            flag_fail("branch", 3'b010);
        end else if (br_taken_o !== exp_taken) begin
            errors++;
            $display("[FAIL] %0t ns: branch taken %b, expected %b", $time, br_taken_o, exp_taken);
        end
    endtask

    task automatic check_illegal();
        checks++;
        if ({wb_valid_o, br_valid_o, illegal_o} !== 3'b001) begin
            flag_fail("illegal instruction", 3'b001);
        end
    endtask

    task automatic check_quiet(input string what);
        if ({wb_valid_o, br_valid_o, illegal_o} !== 3'b000) begin
            flag_fail(what, 3'b000);
        end
    endtask

    // Sample the strobe at the edge, check the outputs mid-cycle
    initial begin : compare
        exp_t e;
        logic strobed;
        forever begin
            @(posedge clk_i);
            strobed = instr_valid_i && rst_n_i;
            @(negedge clk_i);
            if (!strobed) begin
                check_quiet("idle cycle");
            end else if (exp_q.size() == 0) begin
                errors++;
                $display("Strobe at %0t ns has no expected result queued", $time);
            end else begin
                e = exp_q.pop_front();
                case (e.kind)
                    K_WB:    check_wb(e.rd, e.data);
                    K_BR:    check_branch(e.taken);
                    K_ILL:   check_illegal();
                    default: begin
                        checks++;
                        check_quiet("write to x0");
                    end
                endcase
            end
        end
    end

    initial begin : watchdog
        #((MAX_CYCLES + 200) * 100);
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES + 200);
        $display("Errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    initial begin : stimulus
        logic [2:0]                     f3;
        logic                           alt;
        logic [rv_exec_pkg::REG_AW-1:0] rd;
        logic [rv_exec_pkg::REG_AW-1:0] rs;
        logic [rv_exec_pkg::REG_AW-1:0] rt;
        logic [6:0]                     opc;
        logic [31:0]                    v;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (3) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;

        for (int r = 1; r < 32; r++) begin
            load_value(r[4:0], rand_bits(32));
        end
        for (int i = 0; i < N_RR; i++) begin
            f3  = i[2:0];
            alt = (f3 == 3'b000 || f3 == 3'b101) ? 1'(rand_bits(1)) : 1'b0;
            issue(r_type({1'b0, alt, 5'b0}, 5'(rand_bits(5)), 5'(rand_bits(5)), f3,
                         5'(rand_bits(5)), rv_exec_pkg::OPC_OP));
        end
        finish_test("register-register");

        for (int i = 0; i < N_RI; i++) begin
            f3 = i[2:0];
            rd = 5'(rand_bits(5));
            rs = 5'(rand_bits(5));
            if (i % 5 == 4) begin
                issue({20'(rand_bits(20)), rd, rv_exec_pkg::OPC_LUI});
            end else if (f3 == 3'b001 || f3 == 3'b101) begin
                alt = (f3 == 3'b101) ? 1'(rand_bits(1)) : 1'b0;
                issue(r_type({1'b0, alt, 5'b0}, 5'(rand_bits(5)), rs, f3, rd,
                             rv_exec_pkg::OPC_OP_IMM));
            end else begin
                issue(i_type(12'(rand_bits(12)), rs, f3, rd));
            end
        end
        finish_test("register-immediate and LUI");

        for (int i = 0; i < N_BR; i++) begin
            f3 = 3'((i % 6 < 2) ? i % 6 : i % 6 + 2);   // 0 1 4 5 6 7
            case ((i / 6) % 3)
                0: begin                                  // Differ in sign only
                    v = rand_bits(32);
                    load_value(5'd29, v);
                    load_value(5'd30, v ^ 32'h8000_0000);
                    rs = 5'd29;
                    rt = 5'd30;
                end
                1: begin
                    rs = 5'(rand_bits(5));
                    rt = rs;
                end
                default: begin
                    rs = 5'(rand_bits(5));
                    rt = 5'(rand_bits(5));
                end
            endcase
            issue(r_type(7'b0, rt, rs, f3, 5'd0, rv_exec_pkg::OPC_BRANCH));
        end
        finish_test("branch conditions");

        rs = 5'd1;
        rt = 5'd2;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = (i % 8 == 7) ? 5'd0 : 5'(rand_bits(5));
            if (i % 2 == 0) begin
                issue(i_type(12'(rand_bits(12)), rs, 3'b000, rd));
            end else begin
                issue(r_type(7'b0, rt, rs, 3'(rand_bits(3)), rd, rv_exec_pkg::OPC_OP));
            end
            if (rd != '0) begin
                rt = rs;
                rs = rd;
            end
        end
        issue(r_type(7'b0, 5'd0, 5'd0, 3'b110, 5'd7, rv_exec_pkg::OPC_OP)); // x0 reads zero
        finish_test("dependency chains and x0");

        for (int i = 0; i < N_IDLE; i++) begin
            idle(int'(rand_bits(2)));
            issue(i_type(12'(rand_bits(12)), 5'(rand_bits(5)), 3'(rand_bits(3)),
                         5'(rand_bits(5))));
        end
        apply_reset(3);
        for (int r = 1; r < 32; r++) begin
            issue(i_type(12'd0, r[4:0], 3'b000, r[4:0]));
        end
        finish_test("idle cycles and reset");

        for (int r = 1; r < 9; r++) begin
            load_value(r[4:0], rand_bits(32));
        end
        for (int i = 0; i < N_ILL; i++) begin
            rd = 5'(1 + rand_bits(3));
            case (i % 4)
                0: begin
                    opc = 7'(rand_bits(7));
                    while (opc == rv_exec_pkg::OPC_OP || opc == rv_exec_pkg::OPC_OP_IMM ||
                           opc == rv_exec_pkg::OPC_LUI || opc == rv_exec_pkg::OPC_BRANCH) begin
                        opc = 7'(rand_bits(7));
                    end
                    issue({20'(rand_bits(20)), rd, opc});
                end
                1: issue(r_type(7'b0000001, 5'(rand_bits(5)), 5'(rand_bits(5)),
                                3'(rand_bits(3)), rd, rv_exec_pkg::OPC_OP));
                2: issue(r_type(7'b0100000, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'b001, rd,
                                rv_exec_pkg::OPC_OP_IMM));
                default: issue(r_type(7'b0, 5'(rand_bits(5)), 5'(rand_bits(5)),
                                      {2'b01, 1'(rand_bits(1))}, 5'd0,
                                      rv_exec_pkg::OPC_BRANCH));
            endcase
        end
        for (int r = 1; r < 9; r++) begin
            issue(i_type(12'd0, r[4:0], 3'b000, r[4:0]));   // Still the loaded values
        end
        finish_test("illegal instructions");

        $display("Tests: 6, checks: %0d, failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: rv_exec_top.f
common/rv_exec_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
alu/rv_alu.sv
design/rv_exec_top.sv
verif/rv_exec_props.sv
verif/rv_exec_tb.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - common/rv_exec_pkg.sv
  - design/rv_decode.sv
  - design/rv_regfile.sv
  - alu/rv_alu.sv
  - design/rv_exec_top.sv
  - target: test
    files:
      - verif/rv_exec_props.sv
      - verif/rv_exec_tb.sv
